/* include/pci_fifo_config.svh */
/*
  Host to PCI FIFO configuration
  Depth, pointer width and payload field widths shared by the FIFO channels
*/
`ifndef PCI_FIFO_CONFIG_SVH
`define PCI_FIFO_CONFIG_SVH

// Number of entries held by each channel
`define FIFO_DEPTH 7

// Pointer width that covers FIFO_DEPTH entries
`define FIFO_ADDR_W 3

// Payload field widths
`define DATA_W 32
`define BE_W 4
// Command on the request channel and status on the delayed read channel
`define CMD_W 3

`endif

/* verilog/pci_fifo_pkg.sv */
/*
  Host to PCI FIFO types
  Payload layouts of the request and delayed read data channels and the
  flag mode of a channel
*/
`include "pci_fifo_config.svh"

package pci_fifo_pkg;

  // ==========================================================================
  // Channel payloads
  // ==========================================================================

  // Host request word of 39 bits
  // Byte enables are active high with bit 0 for the lowest byte of data
  typedef struct packed {
    logic [`DATA_W-1:0] data;
    logic [`BE_W-1:0]   byte_en;
    logic [`CMD_W-1:0]  command;
  } req_payload_t;

  // Delayed read data word of 35 bits
  typedef struct packed {
    logic [`DATA_W-1:0] data;
    logic [`CMD_W-1:0]  status;
  } dr_payload_t;

  // ==========================================================================
  // Flag modes
  // ==========================================================================

  // FLAG_WITH_DATA makes an entry visible the cycle after its push
  // DATA_BEFORE_FLAG holds the flag back one more cycle so the data has a
  // whole clock to settle before the reader can see it
  typedef enum logic {
    FLAG_WITH_DATA   = 1'b0,
    DATA_BEFORE_FLAG = 1'b1
  } fifo_mode_e;

endpackage

/* verilog/fifo_ctrl_if.sv */
/*
  FIFO storage control
  Write and read port controls sent from a flag block to its storage
*/
`timescale 1ns/1ps
`include "pci_fifo_config.svh"

interface fifo_ctrl_if;
  // Write port strobe and the entry it lands in
  logic                    write_capture;
  logic [`FIFO_ADDR_W-1:0] write_address;
  // Head entry and the read port enable
  logic [`FIFO_ADDR_W-1:0] read_address;
  logic                    read_enable;

  // The flag block owns the pointers
  modport flags (
    output write_capture, write_address, read_address, read_enable
  );

  // The storage only follows them
  modport storage (
    input write_capture, write_address, read_address, read_enable
  );
endinterface

/* verilog/fifo_flags.sv */
/*
  FIFO flag block
  Pointers, occupancy, the registered data available flag and the credit
  return pulse of one channel
*/
`timescale 1ns/1ps
`include "pci_fifo_config.svh"

module fifo_flags (
  input  logic                     write_clk,
  input  logic                     arst_n,
  input  logic                     push,
  input  logic                     remove,
  input  pci_fifo_pkg::fifo_mode_e mode,
  output logic                     available,
  output logic                     credit_return,
  output logic                     overflow,
  output logic                     underflow,
  fifo_ctrl_if.flags               ctrl
);
  // One extra bit so a full count of FIFO_DEPTH always fits
  localparam int cnt_w = `FIFO_ADDR_W + 1;
  localparam logic [`FIFO_ADDR_W-1:0] last_addr = `FIFO_ADDR_W'(`FIFO_DEPTH - 1);
  localparam logic [cnt_w-1:0] depth_count = cnt_w'(`FIFO_DEPTH);

  logic [`FIFO_ADDR_W-1:0] wr_ptr;
  logic [`FIFO_ADDR_W-1:0] rd_ptr;
  logic [cnt_w-1:0]        entry_count;
  logic [cnt_w-1:0]        vis_count;
  logic [cnt_w-1:0]        vis_count_next;
  logic                    full;
  logic                    push_ok;
  logic                    remove_ok;
  logic                    push_show;
  logic                    push_dly;
  logic [1:0]              flag_inc;

  // ==========================================================================
  // Accept and error detection
  // ==========================================================================

  // A push into a full FIFO is dropped
  assign full      = (entry_count == depth_count);
  assign push_ok   = push & ~full;
  assign overflow  = push & full;
  // The reader only ever sees the single available flop
  assign remove_ok = remove & available;
  assign underflow = remove & ~available;

  // Entries become visible now in FLAG_WITH_DATA mode or one edge later
  assign push_show = push_ok & (mode == pci_fifo_pkg::FLAG_WITH_DATA);
  // Two increments are possible only when the mode flips with a push still pending
  assign flag_inc       = 2'(push_show) + 2'(push_dly);
  assign vis_count_next = vis_count + cnt_w'(flag_inc) - cnt_w'(remove_ok);

  // Storage writes at the write pointer and shows the head entry
  assign ctrl.write_capture = push_ok;
  assign ctrl.write_address = wr_ptr;
  assign ctrl.read_address  = rd_ptr;
  // Read port runs whenever the next cycle has a visible entry
  assign ctrl.read_enable   = (vis_count_next != '0);

  // ==========================================================================
  // Pointers and counts
  // ==========================================================================

  always_ff @(posedge write_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      entry_count <= '0;
      vis_count   <= '0;
      push_dly    <= 1'b0;
    end
    else
    begin
      if (push_ok)
      begin
        wr_ptr <= (wr_ptr == last_addr) ? '0 : wr_ptr + 1'b1;
      end
      if (remove_ok)
      begin
        rd_ptr <= (rd_ptr == last_addr) ? '0 : rd_ptr + 1'b1;
      end
      entry_count <= entry_count + cnt_w'(push_ok) - cnt_w'(remove_ok);
      vis_count   <= vis_count_next;
      // Delayed copy of the push for DATA_BEFORE_FLAG
      push_dly    <= push_ok & (mode == pci_fifo_pkg::DATA_BEFORE_FLAG);
    end
  end

  // Single flop flags seen by the reader and the writer's credit model
  always_ff @(posedge write_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      available     <= 1'b0;
      credit_return <= 1'b0;
    end
    else
    begin
      available     <= (vis_count_next != '0);
      credit_return <= remove_ok;
    end
  end
endmodule

/* verilog/fifo_storage.sv */
/*
  FIFO storage
  Flop array of one channel that is written on capture and read by a mux
*/
`timescale 1ns/1ps
`include "pci_fifo_config.svh"

module fifo_storage #(
  parameter type payload_t = logic [7:0]
) (
  input  logic         write_clk,
  input  payload_t     write_data,
  output payload_t     read_data,
  fifo_ctrl_if.storage ctrl
);
  payload_t entries [`FIFO_DEPTH];
  payload_t read_selected;
  logic     read_enable_q;

  // Only the addressed entry loads on a capture
  always_ff @(posedge write_clk)
  begin
    if (ctrl.write_capture)
    begin
      entries[ctrl.write_address] <= write_data;
    end
  end

  // Registered read enable in the style of a synchronous read port
  always_ff @(posedge write_clk)
  begin
    read_enable_q <= ctrl.read_enable;
  end

  // Head entry through the read mux
  assign read_selected = entries[ctrl.read_address];

  // Output is held at zero while nothing is visible
  // so stale entries never reach the reader
  assign read_data = read_enable_q ? read_selected : '0;
endmodule

/* verilog/fifo_ctrl_regs.sv */
/*
  FIFO control registers
  Flag mode of each channel and the sticky overflow and underflow errors
*/
`timescale 1ns/1ps

module fifo_ctrl_regs (
  input  logic                     write_clk,
  input  logic                     arst_n,
  input  logic                     cfg_write,
  input  logic                     cfg_channel,
  input  pci_fifo_pkg::fifo_mode_e cfg_mode,
  input  logic                     err_clear,
  input  logic                     req_overflow,
  input  logic                     req_underflow,
  input  logic                     dr_overflow,
  input  logic                     dr_underflow,
  output pci_fifo_pkg::fifo_mode_e req_mode,
  output pci_fifo_pkg::fifo_mode_e dr_mode,
  output logic                     req_write_error,
  output logic                     req_read_error,
  output logic                     dr_write_error,
  output logic                     dr_read_error
);
  // Error bits in the order req write, req read, dr write, dr read
  logic [3:0] err_pulse;
  logic [3:0] err_q;

  // ==========================================================================
  // Mode registers
  // ==========================================================================

  // cfg_channel 0 is the request channel and 1 the delayed read channel
  always_ff @(posedge write_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      req_mode <= pci_fifo_pkg::FLAG_WITH_DATA;
      dr_mode  <= pci_fifo_pkg::FLAG_WITH_DATA;
    end
    else if (cfg_write)
    begin
      if (cfg_channel)
        dr_mode <= cfg_mode;
      else
        req_mode <= cfg_mode;
    end
  end

  // ==========================================================================
  // Sticky errors
  // ==========================================================================

  assign err_pulse = {req_overflow, req_underflow, dr_overflow, dr_underflow};

  // A new error in the clearing cycle keeps its bit set
  always_ff @(posedge write_clk or negedge arst_n)
  begin
    if (!arst_n)
      err_q <= '0;
    else
      err_q <= err_pulse | (err_q & ~{4{err_clear}});
  end

  assign req_write_error = err_q[3];
  assign req_read_error  = err_q[2];
  assign dr_write_error  = err_q[1];
  assign dr_read_error   = err_q[0];
endmodule

/* verilog/pci_fifo_top.sv */
/*
  Host to PCI FIFO pair
  Request and delayed read data channels with credit flow control and a
  shared block of mode and error registers
*/
`timescale 1ns/1ps
`include "pci_fifo_config.svh"

module pci_fifo_top (
  input  logic                                 write_clk,
  input  logic                                 arst_n,
  // Configuration and error clear
  input  logic                                 cfg_write,
  input  logic                                 cfg_channel,
  input  pci_fifo_pkg::fifo_mode_e             cfg_mode,
  input  logic                                 err_clear,
  // Request channel
  input  logic                                 req_push,
  input  logic [`DATA_W+`BE_W+`CMD_W-1:0]      req_data,
  output logic                                 req_credit_return,
  output logic                                 req_available,
  input  logic                                 req_remove,
  output logic [`DATA_W+`BE_W+`CMD_W-1:0]      req_rd_data,
  output logic                                 req_write_error,
  output logic                                 req_read_error,
  // Delayed read data channel
  input  logic                                 dr_push,
  input  logic [`DATA_W+`CMD_W-1:0]            dr_data,
  output logic                                 dr_credit_return,
  output logic                                 dr_available,
  input  logic                                 dr_remove,
  output logic [`DATA_W+`CMD_W-1:0]            dr_rd_data,
  output logic                                 dr_write_error,
  output logic                                 dr_read_error
);
  pci_fifo_pkg::fifo_mode_e req_mode;
  pci_fifo_pkg::fifo_mode_e dr_mode;
  logic                     req_overflow;
  logic                     req_underflow;
  logic                     dr_overflow;
  logic                     dr_underflow;

  fifo_ctrl_if req_ctrl ();
  fifo_ctrl_if dr_ctrl ();

  // ==========================================================================
  // Request channel
  // ==========================================================================

  fifo_flags req_flags (
    .write_clk     (write_clk),
    .arst_n        (arst_n),
    .push          (req_push),
    .remove        (req_remove),
    .mode          (req_mode),
    .available     (req_available),
    .credit_return (req_credit_return),
    .overflow      (req_overflow),
    .underflow     (req_underflow),
    .ctrl          (req_ctrl)
  );

  fifo_storage #(.payload_t(pci_fifo_pkg::req_payload_t)) req_storage (
    .write_clk  (write_clk),
    .write_data (req_data),
    .read_data  (req_rd_data),
    .ctrl       (req_ctrl)
  );

  // ==========================================================================
  // Delayed read data channel
  // ==========================================================================

  fifo_flags dr_flags (
    .write_clk     (write_clk),
    .arst_n        (arst_n),
    .push          (dr_push),
    .remove        (dr_remove),
    .mode          (dr_mode),
    .available     (dr_available),
    .credit_return (dr_credit_return),
    .overflow      (dr_overflow),
    .underflow     (dr_underflow),
    .ctrl          (dr_ctrl)
  );

  fifo_storage #(.payload_t(pci_fifo_pkg::dr_payload_t)) dr_storage (
    .write_clk  (write_clk),
    .write_data (dr_data),
    .read_data  (dr_rd_data),
    .ctrl       (dr_ctrl)
  );

  // Modes and sticky errors for both channels
  fifo_ctrl_regs ctrl_regs (
    .write_clk       (write_clk),
    .arst_n          (arst_n),
    .cfg_write       (cfg_write),
    .cfg_channel     (cfg_channel),
    .cfg_mode        (cfg_mode),
    .err_clear       (err_clear),
    .req_overflow    (req_overflow),
    .req_underflow   (req_underflow),
    .dr_overflow     (dr_overflow),
    .dr_underflow    (dr_underflow),
    .req_mode        (req_mode),
    .dr_mode         (dr_mode),
    .req_write_error (req_write_error),
    .req_read_error  (req_read_error),
    .dr_write_error  (dr_write_error),
    .dr_read_error   (dr_read_error)
  );
endmodule

/* testbench/pci_fifo_chk.sv */
/*
  FIFO protocol checks
  Credit pulse width, availability after a push and error clearing
*/
`timescale 1ns/1ps

module pci_fifo_chk (
  input logic write_clk,
  input logic arst_n,
  input logic err_clear,
  input logic req_push,
  input logic req_remove,
  input logic req_available,
  input logic req_credit_return,
  input logic req_overflow,
  input logic req_underflow,
  input logic req_write_error,
  input logic req_read_error,
  input logic dr_push,
  input logic dr_remove,
  input logic dr_available,
  input logic dr_credit_return,
  input logic dr_overflow,
  input logic dr_underflow,
  input logic dr_write_error,
  input logic dr_read_error
);
  // Number of failed assertions
  int failures = 0;

  // ==========================================================================
  // Credit return
  // ==========================================================================

  // A credit pulse drops after one cycle unless another remove was accepted
  req_credit_once: assert property (@(posedge write_clk) disable iff (!arst_n)
    req_credit_return && !(req_remove && req_available) |=> !req_credit_return)
  else
  begin
    $error("Request credit return held without a new remove");
    failures++;
  end

  dr_credit_once: assert property (@(posedge write_clk) disable iff (!arst_n)
    dr_credit_return && !(dr_remove && dr_available) |=> !dr_credit_return)
  else
  begin
    $error("Delayed read credit return held without a new remove");
    failures++;
  end

  // ==========================================================================
  // Availability
  // ==========================================================================

  // The slower mode shows the flag two edges after the push
  req_avail_push: assert property (@(posedge write_clk) disable iff (!arst_n)
    $rose(req_available) |-> ($past(req_push) || $past(req_push, 2)))
  else
  begin
    $error("Request data became available without a push");
    failures++;
  end

  dr_avail_push: assert property (@(posedge write_clk) disable iff (!arst_n)
    $rose(dr_available) |-> ($past(dr_push) || $past(dr_push, 2)))
  else
  begin
    $error("Delayed read data became available without a push");
    failures++;
  end

  // ==========================================================================
  // Error clearing
  // ==========================================================================

  req_wr_clear: assert property (@(posedge write_clk) disable iff (!arst_n)
    err_clear && !req_overflow |=> !req_write_error)
  else
  begin
    $error("Request write error survived a clear");
    failures++;
  end

  req_rd_clear: assert property (@(posedge write_clk) disable iff (!arst_n)
    err_clear && !req_underflow |=> !req_read_error)
  else
  begin
    $error("Request read error survived a clear");
    failures++;
  end

  dr_wr_clear: assert property (@(posedge write_clk) disable iff (!arst_n)
    err_clear && !dr_overflow |=> !dr_write_error)
  else
  begin
    $error("Delayed read write error survived a clear");
    failures++;
  end

  dr_rd_clear: assert property (@(posedge write_clk) disable iff (!arst_n)
    err_clear && !dr_underflow |=> !dr_read_error)
  else
  begin
    $error("Delayed read read error survived a clear");
    failures++;
  end
endmodule

// Attached to every instance of the top level
bind pci_fifo_top pci_fifo_chk chk (.*);

/* testbench/pci_fifo_tb.sv */
/*
  Host to PCI FIFO testbench
  Drives both channels with a credit model and reference queues and checks
  order, credits, flag modes and the sticky errors
*/
`timescale 1ns/1ps
`include "pci_fifo_config.svh"

module pci_fifo_tb;
  logic                              write_clk;
  logic                              arst_n;
  logic                              cfg_write;
  logic                              cfg_channel;
  pci_fifo_pkg::fifo_mode_e          cfg_mode;
  logic                              err_clear;
  logic                              req_push;
  logic [`DATA_W+`BE_W+`CMD_W-1:0]   req_data;
  logic                              req_credit_return;
  logic                              req_available;
  logic                              req_remove;
  logic [`DATA_W+`BE_W+`CMD_W-1:0]   req_rd_data;
  logic                              req_write_error;
  logic                              req_read_error;
  logic                              dr_push;
  logic [`DATA_W+`CMD_W-1:0]         dr_data;
  logic                              dr_credit_return;
  logic                              dr_available;
  logic                              dr_remove;
  logic [`DATA_W+`CMD_W-1:0]         dr_rd_data;
  logic                              dr_write_error;
  logic                              dr_read_error;

  // Reference queues hold every accepted word in push order
  pci_fifo_pkg::req_payload_t req_q[$];
  pci_fifo_pkg::dr_payload_t  dr_q[$];
  int req_credits;
  int dr_credits;
  int checks;
  int errors;
  int tests;
  int errors_before;

  pci_fifo_top DUT (.*);

  initial
  begin
    write_clk = 1'b0;
    forever #10 write_clk = ~write_clk;
  end

  // ==========================================================================
  // Helpers
  // ==========================================================================

  // Outputs settle after the rising edge, so the falling edge sees them
  // stable and is also where the next inputs are driven
  task automatic tick();
    @(negedge write_clk);
    if (req_credit_return)
      req_credits++;
    if (dr_credit_return)
      dr_credits++;
    req_push  = 1'b0;
    req_remove = 1'b0;
    dr_push   = 1'b0;
    dr_remove = 1'b0;
    cfg_write = 1'b0;
    err_clear = 1'b0;
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks++;
    assert (actual === expected)
    else
    begin
      $display("FAILED %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // Random word, which spends one credit
  task automatic push_req();
    pci_fifo_pkg::req_payload_t word;
    word.data    = $urandom();
    word.byte_en = 4'($urandom());
    word.command = 3'($urandom());
    req_push = 1'b1;
    req_data = word;
    req_q.push_back(word);
    req_credits--;
  endtask

  task automatic push_dr();
    pci_fifo_pkg::dr_payload_t word;
    word.data   = $urandom();
    word.status = 3'($urandom());
    dr_push = 1'b1;
    dr_data = word;
    dr_q.push_back(word);
    dr_credits--;
  endtask

  // Head on rd_data must match the oldest queued word
  task automatic pop_req();
    pci_fifo_pkg::req_payload_t head;
    if (req_q.size() == 0)
    begin
      $display("Request channel shows data that was never pushed");
      errors++;
    end
    else
    begin
      head = req_q.pop_front();
      check_value("req_rd_data", 64'(req_rd_data), 64'(head));
      req_remove = 1'b1;
    end
  endtask

  task automatic pop_dr();
    pci_fifo_pkg::dr_payload_t head;
    if (dr_q.size() == 0)
    begin
      $display("Delayed read channel shows data that was never pushed");
      errors++;
    end
    else
    begin
      head = dr_q.pop_front();
      check_value("dr_rd_data", 64'(dr_rd_data), 64'(head));
      dr_remove = 1'b1;
    end
  endtask

  task automatic drain_req();
    int idle;
    idle = 0;
    while (req_q.size() > 0 && idle < 20)
    begin
      tick();
      if (req_available)
        pop_req();
      else
        idle++;
    end
    if (req_q.size() > 0)
    begin
      $display("Timeout while draining the request channel");
      errors++;
    end
  endtask

  // Waits until every credit of both channels is back with the writer
  task automatic wait_credits();
    int n;
    n = 0;
    while ((req_credits != `FIFO_DEPTH || dr_credits != `FIFO_DEPTH) && n < 20)
    begin
      tick();
      n++;
    end
    if (req_credits != `FIFO_DEPTH || dr_credits != `FIFO_DEPTH)
    begin
      $display("Timeout while waiting for the credits to return");
      errors++;
    end
  endtask

  task automatic fill_req();
    while (req_credits > 0)
    begin
      tick();
      push_req();
    end
  endtask

  task automatic set_mode(input logic channel, input pci_fifo_pkg::fifo_mode_e mode);
    tick();
    cfg_write   = 1'b1;
    cfg_channel = channel;
    cfg_mode    = mode;
  endtask

  task automatic clear_errors();
    tick();
    err_clear = 1'b1;
    tick();
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("Test %0d %s finished with %0d errors", tests, name, errors - errors_before);
    errors_before = errors;
  endtask

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  initial
  begin
    void'($urandom(32'he380));
    arst_n      = 1'b0;
    cfg_write   = 1'b0;
    cfg_channel = 1'b0;
    cfg_mode    = pci_fifo_pkg::FLAG_WITH_DATA;
    err_clear   = 1'b0;
    req_push    = 1'b0;
    req_data    = '0;
    req_remove  = 1'b0;
    dr_push     = 1'b0;
    dr_data     = '0;
    dr_remove   = 1'b0;
    req_credits = `FIFO_DEPTH;
    dr_credits  = `FIFO_DEPTH;
    checks        = 0;
    errors        = 0;
    tests         = 0;
    errors_before = 0;
    repeat (4) @(negedge write_clk);
    arst_n = 1'b1;

    // Random pushes and removes on the request channel
    for (int i = 0; i < 60; i++)
    begin
      tick();
      if (req_credits > 0 && $urandom_range(1) == 1)
        push_req();
      if (req_available && $urandom_range(1) == 1)
        pop_req();
    end
    drain_req();
    wait_credits();
    finish_test("request order");

    // Without removes the writer runs out of credits and nothing is lost
    fill_req();
    tick();
    tick();
    check_value("req_credits", 64'(req_credits), 64'(0));
    check_value("req_write_error", 64'(req_write_error), 64'(0));
    check_value("req_available", 64'(req_available), 64'(1));
    drain_req();
    wait_credits();
    check_value("req_credits", 64'(req_credits), 64'(`FIFO_DEPTH));
    finish_test("credits");

    // Flag latency of the delayed read channel in both modes
    tick();
    push_dr();
    tick();
    check_value("dr_available", 64'(dr_available), 64'(1));
    pop_dr();
    wait_credits();
    set_mode(1'b1, pci_fifo_pkg::DATA_BEFORE_FLAG);
    tick();
    push_dr();
    tick();
    check_value("dr_available", 64'(dr_available), 64'(0));
    tick();
    check_value("dr_available", 64'(dr_available), 64'(1));
    pop_dr();
    wait_credits();
    set_mode(1'b1, pci_fifo_pkg::FLAG_WITH_DATA);
    finish_test("delayed read and mode");

    // An extra push past the credits is dropped and flagged
    fill_req();
    tick();
    req_push = 1'b1;
    req_data = '1;
    tick();
    check_value("req_write_error", 64'(req_write_error), 64'(1));
    // The other channel's errors stay untouched
    check_value("dr_write_error", 64'(dr_write_error), 64'(0));
    check_value("req_read_error", 64'(req_read_error), 64'(0));
    drain_req();
    wait_credits();
    clear_errors();
    check_value("req_write_error", 64'(req_write_error), 64'(0));
    finish_test("overflow");

    // Remove on an empty channel returns nothing
    tick();
    check_value("dr_available", 64'(dr_available), 64'(0));
    check_value("req_available", 64'(req_available), 64'(0));
    dr_remove  = 1'b1;
    req_remove = 1'b1;
    tick();
    check_value("dr_read_error", 64'(dr_read_error), 64'(1));
    check_value("req_read_error", 64'(req_read_error), 64'(1));
    check_value("dr_credit_return", 64'(dr_credit_return), 64'(0));
    check_value("req_credit_return", 64'(req_credit_return), 64'(0));
    tick();
    tick();
    check_value("dr_credits", 64'(dr_credits), 64'(`FIFO_DEPTH));
    check_value("req_credits", 64'(req_credits), 64'(`FIFO_DEPTH));
    clear_errors();
    check_value("dr_read_error", 64'(dr_read_error), 64'(0));
    check_value("req_read_error", 64'(req_read_error), 64'(0));
    finish_test("underflow");

    // Protocol assertions that fired during the run also fail it
    errors += DUT.chk.failures;
    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end
endmodule

/* list.f */
+incdir+include
verilog/pci_fifo_pkg.sv
verilog/fifo_ctrl_if.sv
verilog/fifo_flags.sv
verilog/fifo_storage.sv
verilog/fifo_ctrl_regs.sv
verilog/pci_fifo_top.sv
testbench/pci_fifo_chk.sv
testbench/pci_fifo_tb.sv

/* Makefile */
# Verilator flow for the host to PCI FIFO pair

TOP = pci_fifo_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

# The run passes only when the log holds the pass message
sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
